// ==== hist_cfg_pkg.sv ====
`default_nettype none

package hist_cfg_pkg;

    // time bins in one pixel histogram
    localparam int BIN_NUM = 8;
    // pixels sharing one histogram memory
    localparam int PIXEL_NUM = 2;
    // events per pixel in each acquisition
    localparam int DATA_NUM = 4;
    // acquisitions per frame
    localparam int ACQ_NUM = 3;
    // width of one bin count
    localparam int COUNT_W = 8;

    // derived widths
    localparam int BIN_W = $clog2(BIN_NUM);
    localparam int PIX_W = $clog2(PIXEL_NUM);
    // word index inside one bank, pixel in the upper bits
    localparam int IDX_W = PIX_W + BIN_W;
    // bank bit on top of the word index
    localparam int ADDR_W = 1 + IDX_W;
    localparam int DATA_CNT_W = $clog2(DATA_NUM);
    localparam int ACQ_CNT_W = $clog2(ACQ_NUM);

    localparam int WORDS_PER_BANK = PIXEL_NUM * BIN_NUM;

endpackage

`default_nettype wire

// ==== hist_bus_pkg.sv ====
`default_nettype none

package hist_bus_pkg;

    // memory read request
    typedef struct packed {
        logic                             en;
        logic [hist_cfg_pkg::ADDR_W-1:0]  addr;
    } mem_rd_req_t;

    // count stores data and marks the word valid, clear only drops the flag
    typedef enum logic {
        WR_COUNT = 1'b0,
        WR_CLEAR = 1'b1
    } mem_wr_op_e;

    // memory write request
    typedef struct packed {
        logic                             en;
        mem_wr_op_e                       op;
        logic [hist_cfg_pkg::ADDR_W-1:0]  addr;
        logic [hist_cfg_pkg::COUNT_W-1:0] data;
    } mem_wr_req_t;

    // one word of the readout stream
    typedef struct packed {
        logic [hist_cfg_pkg::PIX_W-1:0]   pixel;
        logic [hist_cfg_pkg::BIN_W-1:0]   bin;
        logic [hist_cfg_pkg::COUNT_W-1:0] count;
    } hist_word_t;

    // readout FSM states
    typedef enum logic [1:0] {
        RO_IDLE = 2'd0,
        RO_READ = 2'd1,
        RO_LAST = 2'd2
    } ro_state_e;

endpackage

`default_nettype wire

// ==== hist_ram.sv ====
`timescale 1ns/100ps
`default_nettype none

module hist_ram (
    input  wire logic                        clk,
    input  wire logic                        combin_res,
    input  wire hist_bus_pkg::mem_rd_req_t   m_rd,
    input  wire hist_bus_pkg::mem_wr_req_t   m_wr,
    output logic [hist_cfg_pkg::COUNT_W-1:0] rd_count
);
    import hist_cfg_pkg::*;
    import hist_bus_pkg::*;

    // both banks with the bank bit on top of the address
    logic [COUNT_W-1:0]          mem [2*WORDS_PER_BANK];
    // one flag per word so a cleared word reads as zero
    logic [2*WORDS_PER_BANK-1:0] vld;

    // count array only changes on count writes
    always_ff @(posedge clk) begin
        if (m_wr.en && (m_wr.op == WR_COUNT)) begin
            mem[m_wr.addr] <= m_wr.data;
        end
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            vld <= '0;
        end else if (m_wr.en) begin
            vld[m_wr.addr] <= (m_wr.op == WR_COUNT);
        end
    end

    // registered read sees the contents before a same-cycle write
    always_ff @(posedge clk) begin
        if (m_rd.en) begin
            rd_count <= vld[m_rd.addr] ? mem[m_rd.addr] : '0;
        end
    end

endmodule

`default_nettype wire

// ==== hist_arbiter.sv ====
`timescale 1ns/100ps
`default_nettype none

module hist_arbiter (
    input  wire hist_bus_pkg::mem_rd_req_t b_rd,
    input  wire hist_bus_pkg::mem_wr_req_t b_wr,
    input  wire hist_bus_pkg::mem_rd_req_t r_rd,
    input  wire hist_bus_pkg::mem_wr_req_t r_wr,
    output hist_bus_pkg::mem_rd_req_t      m_rd,
    output hist_bus_pkg::mem_wr_req_t      m_wr,
    output logic                           r_rd_grant,
    output logic                           r_wr_grant
);

    // builder owns a port whenever it asks for it
    always_comb begin
        if (b_rd.en) begin
            m_rd = b_rd;
        end else begin
            m_rd = r_rd;
        end
        if (b_wr.en) begin
            m_wr = b_wr;
        end else begin
            m_wr = r_wr;
        end
        // readout only gets an idle port
        r_rd_grant = r_rd.en && !b_rd.en;
        r_wr_grant = r_wr.en && !b_wr.en;
    end

    // builder fills one bank while readout clears the other
    always_comb begin
        a_wr_addr_apart: assert (!(b_wr.en && r_wr.en && (b_wr.addr == r_wr.addr)));
    end

endmodule

`default_nettype wire

// ==== hist_builder.sv ====
`timescale 1ns/100ps
`default_nettype none

module hist_builder (
    input  wire logic                             clk,
    input  wire logic                             combin_res,
    input  wire logic                             event_valid,
    input  wire logic [hist_cfg_pkg::BIN_W-1:0]   event_bin,
    input  wire logic [hist_cfg_pkg::COUNT_W-1:0] rd_count,
    output hist_bus_pkg::mem_rd_req_t             b_rd,
    output hist_bus_pkg::mem_wr_req_t             b_wr,
    output logic [hist_cfg_pkg::COUNT_W-1:0]      bin_count,
    output logic                                  bin_count_valid,
    output logic                                  acq_done,
    output logic                                  frame_done,
    output logic                                  his_num
);
    import hist_cfg_pkg::*;
    import hist_bus_pkg::*;

    // event, pixel and acquisition counters
    logic [DATA_CNT_W-1:0] data_cnt;
    logic [PIX_W-1:0]      pix_cnt;
    logic [ACQ_CNT_W-1:0]  acq_cnt;
    // addressing bank that flips at the sample edge of the closing event
    logic                  fill_bank;
    logic                  acq_end;
    logic                  frame_end;

    // stage 1 holds the read and stage 2 the increment and write
    logic                  s1_valid;
    logic                  s1_acq_end;
    logic                  s1_frame_end;
    logic [ADDR_W-1:0]     s1_addr;
    logic                  s2_valid;
    logic                  s2_acq_end;
    logic                  s2_frame_end;
    logic                  s2_fwd;
    logic [ADDR_W-1:0]     s2_addr;
    logic [COUNT_W-1:0]    s2_fwd_data;
    logic                  fwd_hit;
    logic [COUNT_W-1:0]    base_count;
    logic [COUNT_W-1:0]    new_count;

    // current event closes a pixel run of the last pixel
    assign acq_end   = (data_cnt == DATA_CNT_W'(DATA_NUM - 1)) &&
                       (pix_cnt == PIX_W'(PIXEL_NUM - 1));
    assign frame_end = acq_end && (acq_cnt == ACQ_CNT_W'(ACQ_NUM - 1));

    always_comb begin
        b_rd.en    = s1_valid;
        b_rd.addr  = s1_addr;
        // take the count from a same-cycle write to the same word
        fwd_hit    = s1_valid && s2_valid && (s2_addr == s1_addr);
        base_count = s2_fwd ? s2_fwd_data : rd_count;
        new_count  = base_count + 1'b1;
        b_wr.en    = s2_valid;
        b_wr.op    = WR_COUNT;
        b_wr.addr  = s2_addr;
        b_wr.data  = new_count;
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            data_cnt        <= '0;
            pix_cnt         <= '0;
            acq_cnt         <= '0;
            fill_bank       <= 1'b0;
            s1_valid        <= 1'b0;
            s1_acq_end      <= 1'b0;
            s1_frame_end    <= 1'b0;
            s2_valid        <= 1'b0;
            s2_acq_end      <= 1'b0;
            s2_frame_end    <= 1'b0;
            s2_fwd          <= 1'b0;
            bin_count_valid <= 1'b0;
            acq_done        <= 1'b0;
            frame_done      <= 1'b0;
            his_num         <= 1'b0;
        end else begin
            s1_valid        <= event_valid;
            s1_acq_end      <= event_valid && acq_end;
            s1_frame_end    <= event_valid && frame_end;
            s2_valid        <= s1_valid;
            s2_acq_end      <= s1_acq_end;
            s2_frame_end    <= s1_frame_end;
            s2_fwd          <= fwd_hit;
            bin_count_valid <= s2_valid;
            acq_done        <= s2_acq_end;
            frame_done      <= s2_frame_end;
            // visible bank flips with the write of the closing event
            if (s2_frame_end) begin
                his_num <= ~his_num;
            end
            if (event_valid) begin
                if (data_cnt != DATA_CNT_W'(DATA_NUM - 1)) begin
                    data_cnt <= data_cnt + 1'b1;
                end else begin
                    data_cnt <= '0;
                    pix_cnt  <= acq_end ? '0 : pix_cnt + 1'b1;
                    if (acq_end) begin
                        acq_cnt <= frame_end ? '0 : acq_cnt + 1'b1;
                    end
                end
                if (frame_end) begin
                    fill_bank <= ~fill_bank;
                end
            end
        end
    end

    // address and count payload
    always_ff @(posedge clk) begin
        if (event_valid) begin
            s1_addr <= {fill_bank, pix_cnt, event_bin};
        end
        s2_addr     <= s1_addr;
        s2_fwd_data <= new_count;
        if (s2_valid) begin
            bin_count <= new_count;
        end
    end

    // strobes need an idle cycle between them
    a_event_gap: assert property (@(posedge clk) disable iff (!combin_res)
        event_valid |=> !event_valid);

    // counts only ever land in the bank that his_num shows as filling
    a_wr_fill_bank: assert property (@(posedge clk) disable iff (!combin_res)
        b_wr.en |-> (b_wr.op == WR_COUNT) && (b_wr.addr[ADDR_W-1] == his_num));

endmodule

`default_nettype wire

// ==== hist_readout.sv ====
`timescale 1ns/100ps
`default_nettype none

module hist_readout (
    input  wire logic                             clk,
    input  wire logic                             combin_res,
    input  wire logic                             frame_done,
    input  wire logic                             his_num,
    input  wire logic [hist_cfg_pkg::COUNT_W-1:0] rd_count,
    input  wire logic                             r_rd_grant,
    input  wire logic                             r_wr_grant,
    output hist_bus_pkg::mem_rd_req_t             r_rd,
    output hist_bus_pkg::mem_wr_req_t             r_wr,
    output logic                                  ro_valid,
    output hist_bus_pkg::hist_word_t              ro_word
);
    import hist_cfg_pkg::*;
    import hist_bus_pkg::*;

    ro_state_e         state;
    // word index, pixel-major and bin-ascending
    logic [IDX_W-1:0]  idx;
    // read granted, clear still owed
    logic              rd_done;
    logic [ADDR_W-1:0] addr;

    // drain the bank the builder just left
    assign addr = {~his_num, idx};

    always_comb begin
        r_rd.en       = (state != RO_IDLE) && !rd_done;
        r_rd.addr     = addr;
        r_wr.en       = rd_done;
        r_wr.op       = WR_CLEAR;
        r_wr.addr     = addr;
        r_wr.data     = '0;
        ro_word.pixel = idx[IDX_W-1 -: PIX_W];
        ro_word.bin   = idx[BIN_W-1:0];
        // memory data is valid in the cycle after the granted read
        ro_word.count = rd_count;
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            state    <= RO_IDLE;
            idx      <= '0;
            rd_done  <= 1'b0;
            ro_valid <= 1'b0;
        end else begin
            ro_valid <= r_rd.en && r_rd_grant;
            case (state)
                RO_IDLE: begin
                    if (frame_done) begin
                        state <= RO_READ;
                        idx   <= '0;
                    end
                end
                RO_READ, RO_LAST: begin
                    if (r_rd.en && r_rd_grant) begin
                        rd_done <= 1'b1;
                    end else if (rd_done && r_wr_grant) begin
                        // word read and cleared, step on
                        rd_done <= 1'b0;
                        idx     <= idx + 1'b1;
                        if (state == RO_LAST) begin
                            state <= RO_IDLE;
                        end else if (idx == IDX_W'(WORDS_PER_BANK - 2)) begin
                            state <= RO_LAST;
                        end
                    end
                end
                default: state <= RO_IDLE;
            endcase
        end
    end

    // previous bank must be drained before the next frame ends
    a_no_overrun: assert property (@(posedge clk) disable iff (!combin_res)
        frame_done |-> (state == RO_IDLE));

endmodule

`default_nettype wire

// ==== hist_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module hist_top (
    input  wire logic                             clk,
    input  wire logic                             combin_res,
    input  wire logic                             event_valid,
    input  wire logic [hist_cfg_pkg::BIN_W-1:0]   event_bin,
    output logic [hist_cfg_pkg::COUNT_W-1:0]      bin_count,
    output logic                                  bin_count_valid,
    output logic                                  acq_done,
    output logic                                  his_num,
    output logic                                  ro_valid,
    output hist_bus_pkg::hist_word_t              ro_word
);
    import hist_cfg_pkg::*;
    import hist_bus_pkg::*;

    mem_rd_req_t        b_rd;
    mem_wr_req_t        b_wr;
    mem_rd_req_t        r_rd;
    mem_wr_req_t        r_wr;
    mem_rd_req_t        m_rd;
    mem_wr_req_t        m_wr;
    logic               r_rd_grant;
    logic               r_wr_grant;
    // shared read data, each side knows its own reads
    logic [COUNT_W-1:0] rd_count;
    logic               frame_done;

    hist_builder u_builder (
        .clk(clk), .combin_res(combin_res), .event_valid(event_valid),
        .event_bin(event_bin), .rd_count(rd_count), .b_rd(b_rd), .b_wr(b_wr),
        .bin_count(bin_count), .bin_count_valid(bin_count_valid),
        .acq_done(acq_done), .frame_done(frame_done), .his_num(his_num)
    );

    hist_readout u_readout (
        .clk(clk), .combin_res(combin_res), .frame_done(frame_done),
        .his_num(his_num), .rd_count(rd_count), .r_rd_grant(r_rd_grant),
        .r_wr_grant(r_wr_grant), .r_rd(r_rd), .r_wr(r_wr),
        .ro_valid(ro_valid), .ro_word(ro_word)
    );

    hist_arbiter u_arbiter (
        .b_rd(b_rd), .b_wr(b_wr), .r_rd(r_rd), .r_wr(r_wr), .m_rd(m_rd),
        .m_wr(m_wr), .r_rd_grant(r_rd_grant), .r_wr_grant(r_wr_grant)
    );

    hist_ram u_ram (
        .clk(clk), .combin_res(combin_res), .m_rd(m_rd), .m_wr(m_wr),
        .rd_count(rd_count)
    );

endmodule

`default_nettype wire

// ==== hist_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module hist_tb;
    import hist_cfg_pkg::*;
    import hist_bus_pkg::*;

    localparam int FRAMES       = 3;
    localparam int ACQ_EVENTS   = PIXEL_NUM * DATA_NUM;
    localparam int FRAME_EVENTS = ACQ_EVENTS * ACQ_NUM;
    // per frame record in the data file holds codes, running counts and bank words
    localparam int REC_LEN      = 2 * FRAME_EVENTS + WORDS_PER_BANK;
    // at most 4 cycles per event plus reset and the last drain
    localparam int CYCLE_LIMIT  = FRAMES * FRAME_EVENTS * 4 + 150;
    localparam logic [31:0] SEED = 32'h79f8d12f;

    logic               clk;
    logic               combin_res;
    logic               event_valid;
    logic [BIN_W-1:0]   event_bin;
    logic [COUNT_W-1:0] bin_count;
    logic               bin_count_valid;
    logic               acq_done;
    logic               his_num;
    logic               ro_valid;
    hist_word_t         ro_word;

    logic [COUNT_W-1:0] tests_mem [0:FRAMES*REC_LEN-1];
    int                 cyc = 0;
    int                 gap;
    int                 main_errors = 0;
    int                 total;
    int                 failed;

    // events in flight with sample edge, expected count and run index
    int                 ev_edge_q [$];
    logic [COUNT_W-1:0] ev_cnt_q [$];
    int                 ev_idx_q [$];

    // event side monitor state
    int                 ev_edge;
    logic [COUNT_W-1:0] ev_cnt;
    int                 ev_idx;
    logic               acq_exp;
    logic               his_exp = 1'b0;
    int                 acq_seen = 0;
    int                 frames_closed = 0;
    int                 ev_frame_err = 0;
    int                 ev_errors = 0;
    int                 ev_tests_failed = 0;

    // readout side monitor state
    int                 ro_seen = 0;
    int                 ro_frame;
    int                 ro_w;
    hist_word_t         exp_word;
    int                 ro_frame_err = 0;
    int                 ro_errors = 0;
    int                 ro_tests_failed = 0;

    hist_top uut (
        .clk(clk), .combin_res(combin_res), .event_valid(event_valid),
        .event_bin(event_bin), .bin_count(bin_count), .bin_count_valid(bin_count_valid),
        .acq_done(acq_done), .his_num(his_num), .ro_valid(ro_valid), .ro_word(ro_word)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    initial begin
        while (cyc < CYCLE_LIMIT) @(posedge clk);
        $display("ERROR: run stopped at cycle %0d, events or readout never completed", cyc);
        $display("TESTS FAILED");
        $finish;
    end

    function automatic string verdict(input int errs);
        if (errs == 0) begin
            return "ok";
        end
        return $sformatf("%0d errors", errs);
    endfunction

    // one strobe followed by gap idle cycles
    // starts 1 ns after a rising edge
    task automatic send_event(input logic [BIN_W-1:0] bin, input logic [COUNT_W-1:0] cnt,
                              input int idx, input int idle);
        event_valid = 1'b1;
        event_bin   = bin;
        // sampled at the next edge
        ev_edge_q.push_back(cyc + 1);
        ev_cnt_q.push_back(cnt);
        ev_idx_q.push_back(idx);
        @(posedge clk);
        #1;
        event_valid = 1'b0;
        repeat (idle) begin
            @(posedge clk);
            #1;
        end
    endtask

    // frame bookkeeping once an event has left the pipeline
    task automatic close_event();
        if (ev_idx % FRAME_EVENTS == FRAME_EVENTS - 1) begin
            his_exp = ~his_exp;
            frames_closed++;
            if (acq_seen != ACQ_NUM) begin
                $display("ERROR: frame %0d saw %0d acq_done pulses instead of %0d",
                         frames_closed, acq_seen, ACQ_NUM);
                ev_frame_err++;
            end
            acq_seen = 0;
            $display("frame %0d counts, %0d events: %s", frames_closed, FRAME_EVENTS,
                     verdict(ev_frame_err));
            if (ev_frame_err != 0) begin
                ev_tests_failed++;
            end
            ev_errors += ev_frame_err;
            ev_frame_err = 0;
        end
    endtask

    // event results sampled mid-cycle
    always @(negedge clk) begin
        if (combin_res) begin
            if (acq_done) begin
                acq_seen++;
            end
            if (bin_count_valid) begin
                if (ev_idx_q.size() == 0) begin
                    $display("ERROR: bin_count_valid at cycle %0d with no event in flight", cyc);
                    ev_frame_err++;
                end else begin
                    ev_edge = ev_edge_q.pop_front();
                    ev_cnt  = ev_cnt_q.pop_front();
                    ev_idx  = ev_idx_q.pop_front();
                    if (cyc != ev_edge + 2) begin
                        $display("ERROR: event %0d result came %0d cycles after sampling, not 2",
                                 ev_idx, cyc - ev_edge);
                        ev_frame_err++;
                    end
                    if (bin_count !== ev_cnt) begin
                        $display("FAILED bin_count event %0d: got 0x%h expected 0x%h",
                                 ev_idx, bin_count, ev_cnt);
                        ev_frame_err++;
                    end
                    // last event of every acquisition
                    acq_exp = (ev_idx % ACQ_EVENTS) == ACQ_EVENTS - 1;
                    if (acq_done !== acq_exp) begin
                        $display("FAILED acq_done event %0d: got 0x%h expected 0x%h",
                                 ev_idx, acq_done, acq_exp);
                        ev_frame_err++;
                    end
                    close_event();
                end
            end else begin
                if (acq_done) begin
                    $display("ERROR: acq_done pulsed at cycle %0d without a count", cyc);
                    ev_frame_err++;
                end
                if (ev_idx_q.size() != 0 && cyc > ev_edge_q[0] + 2) begin
                    ev_edge = ev_edge_q.pop_front();
                    ev_cnt  = ev_cnt_q.pop_front();
                    ev_idx  = ev_idx_q.pop_front();
                    $display("ERROR: event %0d never produced bin_count_valid", ev_idx);
                    ev_frame_err++;
                    close_event();
                end
            end
            if (his_num !== his_exp) begin
                $display("FAILED his_num cycle %0d: got 0x%h expected 0x%h", cyc, his_num, his_exp);
                ev_frame_err++;
            end
        end
    end

    // readout stream in pixel-major and bin-ascending order per frame
    always @(negedge clk) begin
        if (combin_res && ro_valid) begin
            if (ro_seen >= WORDS_PER_BANK * frames_closed) begin
                $display("ERROR: readout word at cycle %0d with no closed frame to drain", cyc);
                ro_frame_err++;
            end else begin
                ro_frame       = ro_seen / WORDS_PER_BANK;
                ro_w           = ro_seen % WORDS_PER_BANK;
                exp_word.pixel = PIX_W'(ro_w / BIN_NUM);
                exp_word.bin   = BIN_W'(ro_w % BIN_NUM);
                exp_word.count = tests_mem[ro_frame * REC_LEN + 2 * FRAME_EVENTS + ro_w];
                if (ro_word.pixel !== exp_word.pixel) begin
                    $display("FAILED ro_word.pixel word %0d: got 0x%h expected 0x%h",
                             ro_w, ro_word.pixel, exp_word.pixel);
                    ro_frame_err++;
                end
                if (ro_word.bin !== exp_word.bin) begin
                    $display("FAILED ro_word.bin word %0d: got 0x%h expected 0x%h",
                             ro_w, ro_word.bin, exp_word.bin);
                    ro_frame_err++;
                end
                if (ro_word.count !== exp_word.count) begin
                    $display("FAILED ro_word.count word %0d: got 0x%h expected 0x%h",
                             ro_w, ro_word.count, exp_word.count);
                    ro_frame_err++;
                end
                ro_seen++;
                if (ro_w == WORDS_PER_BANK - 1) begin
                    $display("frame %0d readout, %0d words: %s", ro_frame + 1, WORDS_PER_BANK,
                             verdict(ro_frame_err));
                    if (ro_frame_err != 0) begin
                        ro_tests_failed++;
                    end
                    ro_errors += ro_frame_err;
                    ro_frame_err = 0;
                end
            end
        end
    end

    initial begin
        void'($urandom(SEED));
        combin_res  = 1'b0;
        event_valid = 1'b0;
        event_bin   = '0;
        $readmemh("hist_tests.txt", tests_mem);
        repeat (4) @(posedge clk);
        #1;
        combin_res = 1'b1;

        // quiet outputs before the first event
        @(negedge clk);
        if (ro_valid !== 1'b0) begin
            $display("FAILED ro_valid after reset: got 0x%h expected 0x0", ro_valid);
            main_errors++;
        end
        if (acq_done !== 1'b0) begin
            $display("FAILED acq_done after reset: got 0x%h expected 0x0", acq_done);
            main_errors++;
        end
        if (bin_count_valid !== 1'b0) begin
            $display("FAILED bin_count_valid after reset: got 0x%h expected 0x0",
                     bin_count_valid);
            main_errors++;
        end
        if (his_num !== 1'b0) begin
            $display("FAILED his_num after reset: got 0x%h expected 0x0", his_num);
            main_errors++;
        end
        $display("reset state: %s", verdict(main_errors));

        @(posedge clk);
        #1;
        for (int f = 0; f < FRAMES; f++) begin
            for (int k = 0; k < FRAME_EVENTS; k++) begin
                gap = 1 + int'($urandom % 3);
                send_event(tests_mem[f * REC_LEN + k][BIN_W-1:0],
                           tests_mem[f * REC_LEN + FRAME_EVENTS + k],
                           f * FRAME_EVENTS + k, gap);
            end
        end

        // wait for the last bank to drain and then a few quiet cycles for stray strobes
        while (ro_seen < FRAMES * WORDS_PER_BANK || ev_idx_q.size() != 0) @(posedge clk);
        repeat (8) @(posedge clk);

        total  = main_errors + ev_errors + ev_frame_err + ro_errors + ro_frame_err;
        failed = ev_tests_failed + ro_tests_failed + ((main_errors != 0) ? 1 : 0);
        $display("summary: %0d tests, %0d failed, %0d errors", 1 + 2 * FRAMES, failed, total);
        if (total == 0 && failed == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
hist_cfg_pkg.sv
hist_bus_pkg.sv
hist_ram.sv
hist_arbiter.sv
hist_builder.sv
hist_readout.sv
hist_top.sv
hist_tb.sv

// ==== Makefile ====
TOP := hist_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f sim.f --top-module $(TOP) -o $(TOP)

run: build
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TESTS PASSED"

lint:
	verilator --lint-only -Wall --timing -f sim.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// ==== hist_tests.txt ====
// per frame: 24 event bin codes, then 24 expected running counts, then 16 bank words
// bank words are pixel-major and bin-ascending, every value in hex
// frame 1, fills bank 0
01 03 01 05 06 06 02 04 00 01 03 07
04 00 06 02 01 02 05 05 07 06 04 06
01 01 02 01 01 02 01 01 01 03 02 01
02 01 03 02 04 01 02 03 01 04 03 05
01 04 01 02 00 03 00 01
01 00 02 00 03 00 05 01
// frame 2, fills bank 1
02 02 07 00 03 05 03 01 02 04 06 02
01 01 05 03 00 07 02 04 05 03 00 01
01 02 01 01 01 01 02 01 03 01 01 04
02 03 02 03 02 02 05 02 03 04 01 04
02 00 05 00 02 00 01 02
01 04 00 04 00 03 00 00
// frame 3, bank 0 again, repeated bins back to back
01 01 01 01 06 06 06 00 05 05 03 03
06 06 02 02 01 01 07 07 04 04 04 04
01 02 03 04 01 02 03 01 01 02 01 02
04 05 01 02 05 06 01 02 01 02 03 04
00 06 00 02 00 02 00 02
01 00 02 00 04 00 05 00
